// ==== src.f ====
verilog/spi_pkg.sv
verilog/spi_cmd_if.sv
verilog/spi_edge_if.sv
verilog/spi_sequencer.sv
verilog/spi_sclk_gen.sv
verilog/spi_shift_engine.sv
verilog/spi_master_top.sv
sim/spi_slave_model.sv
sim/tb_spi_master.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_spi_master \
    --Mdir obj_dir \
    -f src.f

./obj_dir/Vtb_spi_master | tee sim.log

if grep -qF "** FAIL **" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation passed"

// ==== sim/tb_spi_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_spi_master;
    import spi_pkg::*;

    localparam int DATA_WIDTH    = 8;
    localparam int NUM_SLAVES    = 4;
    localparam int SEL_W         = $clog2(NUM_SLAVES);
    localparam int MAX_DIV       = 3;
    localparam int NUM_TRANSFERS = 4 * 3 * NUM_SLAVES;
    localparam int TIMEOUT       =
        NUM_TRANSFERS * (2 + 2 * DATA_WIDTH * (MAX_DIV + 1) + 4) + 100;

    logic                  clk;
    logic                  rst_n;
    logic [DATA_WIDTH-1:0] tx_data;
    logic [SEL_W-1:0]      slave_sel;
    logic                  start_transfer;
    logic                  cpol;
    logic                  cpha;
    logic [div_width-1:0]  clk_div;
    logic [DATA_WIDTH-1:0] rx_data;
    logic                  transfer_done;
    logic                  busy;
    logic                  spi_clk;
    logic                  spi_mosi;
    logic                  spi_miso;
    logic [NUM_SLAVES-1:0] spi_cs_n;

    // Slave model setup and what it saw
    logic [SEL_W-1:0]      slv_addr;
    logic                  slv_cpol;
    logic                  slv_cpha;
    logic [DATA_WIDTH-1:0] slv_reply;
    logic [DATA_WIDTH-1:0] slv_rx_word;
    int                    slv_bits;

    logic [SEL_W-1:0]      exp_sel;
    logic                  last_cpol;
    integer                seed;
    int                    errors;
    int                    transfers;
    int                    cycles = 0;

    spi_master_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .tx_data       (tx_data),
        .slave_sel     (slave_sel),
        .start_transfer(start_transfer),
        .cpol          (cpol),
        .cpha          (cpha),
        .clk_div       (clk_div),
        .rx_data       (rx_data),
        .transfer_done (transfer_done),
        .busy          (busy),
        .spi_clk       (spi_clk),
        .spi_mosi      (spi_mosi),
        .spi_miso      (spi_miso),
        .spi_cs_n      (spi_cs_n)
    );

    spi_slave_model #(
        .DATA_WIDTH(DATA_WIDTH),
        .NUM_SLAVES(NUM_SLAVES)
    ) slave (
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_cs_n (spi_cs_n),
        .addr     (slv_addr),
        .cpol     (slv_cpol),
        .cpha     (slv_cpha),
        .reply    (slv_reply),
        .spi_miso (spi_miso),
        .rx_word  (slv_rx_word),
        .bit_count(slv_bits)
    );

    function automatic logic [NUM_SLAVES-1:0] cs_pattern(input logic [SEL_W-1:0] sel);
        logic [NUM_SLAVES-1:0] pattern;
        pattern      = '1;
        pattern[sel] = 1'b0;
        return pattern;
    endfunction

    function automatic logic [div_width-1:0] div_value(input int idx);
        logic [div_width-1:0] v;
        case (idx)
            0:       v = '0;
            1:       v = div_width'(1);
            default: v = div_width'(MAX_DIV);
        endcase
        return v;
    endfunction

    function automatic void fail_value(input string test, input string what,
                                       input int expected, input int actual);
        errors++;
        $display("FAILED %s %s: expected 0x%0h, actual 0x%0h", test, what, expected, actual);
    endfunction

    function automatic void fail_text(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endfunction

    a_cs_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (!busy && !transfer_done) |-> (spi_cs_n == '1))
        else fail_value("cs_idle", "spi_cs_n", int'({NUM_SLAVES{1'b1}}),
                        int'($sampled(spi_cs_n)));

    a_cs_select: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> (spi_cs_n == cs_pattern(exp_sel)))
        else fail_value("cs_select", "spi_cs_n", int'(cs_pattern($sampled(exp_sel))),
                        int'($sampled(spi_cs_n)));

    a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (spi_cs_n == '1) |-> (spi_clk == last_cpol))
        else fail_value("sclk_idle", "spi_clk", int'($sampled(last_cpol)),
                        int'($sampled(spi_clk)));

    a_sclk_done: assert property (@(posedge clk) disable iff (!rst_n)
        transfer_done |-> (spi_clk == last_cpol))
        else fail_value("sclk_done", "spi_clk", int'($sampled(last_cpol)),
                        int'($sampled(spi_clk)));

    a_done_state: assert property (@(posedge clk) disable iff (!rst_n)
        transfer_done |-> ((dut.u_seq.state == st_complete) && !busy))
        else fail_text("transfer_done outside the complete state or together with busy");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        transfer_done |=> !transfer_done)
        else fail_text("transfer_done stayed high for more than one cycle");

    task automatic run_transfer(input logic pol, input logic pha,
                                input logic [div_width-1:0] div, input logic [SEL_W-1:0] sel);
        string                 name;
        logic [31:0]           rnd;
        logic [DATA_WIDTH-1:0] tx;
        logic [DATA_WIDTH-1:0] reply;
        int                    exp_done;
        int                    cyc;
        bit                    finished;
        bit                    got_done;

        name     = $sformatf("mode%0d_div%0d_cs%0d", {pol, pha}, div, sel);
        rnd      = $random(seed);
        tx       = rnd[DATA_WIDTH-1:0];
        reply    = rnd[2*DATA_WIDTH-1:DATA_WIDTH];
        exp_done = 2 + 2 * DATA_WIDTH * (int'(div) + 1);
        cyc      = 0;
        finished = 1'b0;
        got_done = 1'b0;

        @(posedge clk);
        #1;
        tx_data        = tx;
        slave_sel      = sel;
        cpol           = pol;
        cpha           = pha;
        clk_div        = div;
        start_transfer = 1'b1;
        slv_addr       = sel;
        slv_cpol       = pol;
        slv_cpha       = pha;
        slv_reply      = reply;
        exp_sel        = sel;

        while (!finished) begin
            @(negedge clk);
            if (cyc == 1)
                last_cpol = pol;
            if (transfer_done) begin
                finished = 1'b1;
                got_done = 1'b1;
                assert (cyc == exp_done) else fail_value(name, "done cycle", exp_done, cyc);
                assert (rx_data == reply)
                    else fail_value(name, "rx_data", int'(reply), int'(rx_data));
                assert (slv_rx_word == tx)
                    else fail_value(name, "slave word", int'(tx), int'(slv_rx_word));
                assert (slv_bits == DATA_WIDTH)
                    else fail_value(name, "slave bits", DATA_WIDTH, slv_bits);
            end else begin
                assert (cyc < exp_done)
                    else fail_text($sformatf("%s: no transfer_done by cycle %0d", name, cyc));
                assert (busy == (cyc >= 1))
                    else fail_value(name, "busy", int'(cyc >= 1), int'(busy));
                if (cyc >= exp_done)
                    finished = 1'b1;
            end
            if (!finished) begin
                @(posedge clk);
                #1;
                cyc++;
                // Stray start mid-transfer with a different command
                if (cyc == 3) begin
                    start_transfer = 1'b1;
                    tx_data        = ~tx;
                    slave_sel      = sel + 1'b1;
                    cpol           = ~pol;
                    cpha           = ~pha;
                    clk_div        = div + 1'b1;
                end else begin
                    start_transfer = 1'b0;
                end
            end
        end

        if (got_done) begin
            repeat (3) begin
                @(negedge clk);
                assert (!busy && !transfer_done)
                    else fail_text($sformatf("%s: a second transfer followed", name));
                assert (rx_data == reply)
                    else fail_value(name, "held rx_data", int'(reply), int'(rx_data));
            end
        end
        transfers++;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        rst_n          = 1'b0;
        start_transfer = 1'b0;
        tx_data        = '0;
        slave_sel      = '0;
        cpol           = 1'b0;
        cpha           = 1'b0;
        clk_div        = '0;
        slv_addr       = '0;
        slv_cpol       = 1'b0;
        slv_cpha       = 1'b0;
        slv_reply      = '0;
        exp_sel        = '0;
        last_cpol      = 1'b0;
        seed           = 32'hd287;
        errors         = 0;
        transfers      = 0;

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        @(negedge clk);
        assert (!busy && !transfer_done && !spi_mosi)
            else fail_text("busy, transfer_done or spi_mosi high after reset");
        assert (spi_cs_n == '1)
            else fail_value("reset", "spi_cs_n", int'({NUM_SLAVES{1'b1}}), int'(spi_cs_n));
        assert (spi_clk == 1'b0) else fail_value("reset", "spi_clk", 0, int'(spi_clk));

        for (int m = 0; m < 4; m++) begin
            for (int d = 0; d < 3; d++) begin
                for (int s = 0; s < NUM_SLAVES; s++) begin
                    run_transfer(m[1], m[0], div_value(d), s[SEL_W-1:0]);
                end
            end
        end

        $display("transfers: %0d, errors: %0d", transfers, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/spi_slave_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_slave_model #(
    parameter int DATA_WIDTH = 8,
    parameter int NUM_SLAVES = 4
) (
    input  wire logic                          spi_clk,
    input  wire logic                          spi_mosi,
    input  wire logic [NUM_SLAVES-1:0]         spi_cs_n,
    input  wire logic [$clog2(NUM_SLAVES)-1:0] addr,
    input  wire logic                          cpol,
    input  wire logic                          cpha,
    input  wire logic [DATA_WIDTH-1:0]         reply,
    output logic                               spi_miso,
    output logic      [DATA_WIDTH-1:0]         rx_word,
    output int                                 bit_count
);

    logic                  cs_n;
    logic [DATA_WIDTH-1:0] tx_sreg;
    logic                  lead;

    assign cs_n = spi_cs_n[addr];

    initial begin
        spi_miso  = 1'b0;
        rx_word   = '0;
        bit_count = 0;
        tx_sreg   = '0;
        lead      = 1'b0;
        forever begin
            wait (cs_n === 1'b0);
            // Select edge may coincide with a polarity change, skip it
            #1;
            rx_word   = '0;
            bit_count = 0;
            if (cpha) begin
                tx_sreg = reply;
            end else begin
                spi_miso = reply[DATA_WIDTH-1];
                tx_sreg  = reply << 1;
            end
            while (cs_n === 1'b0) begin
                @(spi_clk or cs_n);
                if (cs_n === 1'b0) begin
                    lead = (spi_clk != cpol);
                    // Mode 0/2 sample on leading, mode 1/3 on trailing
                    if (lead != cpha) begin
                        rx_word   = {rx_word[DATA_WIDTH-2:0], spi_mosi};
                        bit_count = bit_count + 1;
                    end else begin
                        spi_miso = tx_sreg[DATA_WIDTH-1];
                        tx_sreg  = tx_sreg << 1;
                    end
                end
            end
            spi_miso = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/spi_master_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_master_top #(
    parameter int DATA_WIDTH = 8,
    parameter int NUM_SLAVES = 4
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic [DATA_WIDTH-1:0]         tx_data,
    input  wire logic [$clog2(NUM_SLAVES)-1:0] slave_sel,
    input  wire logic                          start_transfer,
    input  wire logic                          cpol,
    input  wire logic                          cpha,
    input  wire logic [spi_pkg::div_width-1:0] clk_div,
    output logic      [DATA_WIDTH-1:0]         rx_data,
    output logic                               transfer_done,
    output logic                               busy,
    output logic                               spi_clk,
    output logic                               spi_mosi,
    input  wire logic                          spi_miso,
    output logic      [NUM_SLAVES-1:0]         spi_cs_n
);

    spi_cmd_if #(.DATA_WIDTH(DATA_WIDTH)) cmd_bus ();
    spi_edge_if edge_bus ();

    spi_sequencer #(
        .DATA_WIDTH(DATA_WIDTH),
        .NUM_SLAVES(NUM_SLAVES)
    ) u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_transfer(start_transfer),
        .tx_data       (tx_data),
        .slave_sel     (slave_sel),
        .cpol          (cpol),
        .cpha          (cpha),
        .clk_div       (clk_div),
        .cmd           (cmd_bus.seq_mp),
        .rx_data       (rx_data),
        .transfer_done (transfer_done),
        .busy          (busy),
        .spi_cs_n      (spi_cs_n)
    );

    spi_sclk_gen #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_sclk (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd     (cmd_bus.sclk_mp),
        .edge_bus(edge_bus.gen_mp)
    );

    spi_shift_engine #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_shift (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd     (cmd_bus.shift_mp),
        .edge_bus(edge_bus.shift_mp),
        .spi_miso(spi_miso),
        .spi_mosi(spi_mosi)
    );

    assign spi_clk = edge_bus.sclk;

endmodule

`default_nettype wire

// ==== verilog/spi_shift_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_shift_engine #(
    parameter int DATA_WIDTH = 8
) (
    input  wire logic    clk,
    input  wire logic    rst_n,
    spi_cmd_if.shift_mp  cmd,
    spi_edge_if.shift_mp edge_bus,
    input  wire logic    spi_miso,
    output logic         spi_mosi
);

    logic [DATA_WIDTH-1:0] tx_sreg;
    logic [DATA_WIDTH-1:0] rx_sreg;
    logic                  mosi_q;
    logic                  drive_pulse;
    logic                  sample_pulse;

    // Mode 0/2 sample on leading, 1/3 drive on leading
    assign drive_pulse  = cmd.cpha ? edge_bus.lead_edge  : edge_bus.trail_edge;
    assign sample_pulse = cmd.cpha ? edge_bus.trail_edge : edge_bus.lead_edge;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mosi_q <= 1'b0;
        end else if (cmd.load) begin
            mosi_q <= cmd.tx_word[DATA_WIDTH-1];
        end else if (drive_pulse) begin
            mosi_q <= tx_sreg[DATA_WIDTH-1];
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.load) begin
            // With cpha low the MSB is already on the line
            if (cmd.cpha)
                tx_sreg <= cmd.tx_word;
            else
                tx_sreg <= {cmd.tx_word[DATA_WIDTH-2:0], 1'b0};
        end else if (drive_pulse) begin
            tx_sreg <= {tx_sreg[DATA_WIDTH-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (sample_pulse)
            rx_sreg <= {rx_sreg[DATA_WIDTH-2:0], spi_miso};
    end

    // MSB goes out combinationally during setup
    assign spi_mosi = cmd.load ? cmd.tx_word[DATA_WIDTH-1] : mosi_q;

    assign cmd.rx_word = rx_sreg;

endmodule

`default_nettype wire

// ==== verilog/spi_sclk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_sclk_gen #(
    parameter int DATA_WIDTH = 8
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    spi_cmd_if.sclk_mp cmd,
    spi_edge_if.gen_mp edge_bus
);
    import spi_pkg::*;

    localparam int EDGE_W = $clog2(2 * DATA_WIDTH);

    logic [div_width-1:0] div_cnt;
    logic [EDGE_W-1:0]    edge_cnt;
    logic                 sclk_q;
    logic                 tick;

    // Half period ends this cycle
    assign tick = cmd.run && (div_cnt == cmd.clk_div);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt  <= '0;
            edge_cnt <= '0;
            sclk_q   <= 1'b0;
        end else if (!cmd.run) begin
            div_cnt  <= '0;
            edge_cnt <= '0;
            sclk_q   <= cmd.cpol;
        end else if (tick) begin
            div_cnt  <= '0;
            edge_cnt <= edge_cnt + 1'b1;
            sclk_q   <= ~sclk_q;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Leaving the idle level is the leading edge
    assign edge_bus.lead_edge  = tick && (sclk_q == cmd.cpol);
    assign edge_bus.trail_edge = tick && (sclk_q != cmd.cpol);

    assign cmd.last_edge = tick && (edge_cnt == EDGE_W'(2 * DATA_WIDTH - 1));

    // Pin follows the new polarity as soon as the command is latched
    assign edge_bus.sclk = cmd.run ? sclk_q : cmd.cpol;

    a_edge_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(edge_bus.lead_edge && edge_bus.trail_edge)
    );

    // Sequencer must leave transfer right after the final edge
    a_run_ends: assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd.last_edge |=> !cmd.run
    );

endmodule

`default_nettype wire

// ==== verilog/spi_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_sequencer #(
    parameter int DATA_WIDTH = 8,
    parameter int NUM_SLAVES = 4
) (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             start_transfer,
    input  wire logic [DATA_WIDTH-1:0]            tx_data,
    input  wire logic [$clog2(NUM_SLAVES)-1:0]    slave_sel,
    input  wire logic                             cpol,
    input  wire logic                             cpha,
    input  wire logic [spi_pkg::div_width-1:0]    clk_div,
    spi_cmd_if.seq_mp                             cmd,
    output logic      [DATA_WIDTH-1:0]            rx_data,
    output logic                                  transfer_done,
    output logic                                  busy,
    output logic      [NUM_SLAVES-1:0]            spi_cs_n
);
    import spi_pkg::*;

    localparam int SEL_W = $clog2(NUM_SLAVES);

    logic [state_width-1:0] state;
    logic [state_width-1:0] next_state;
    logic                   accept;

    logic [DATA_WIDTH-1:0]  tx_q;
    logic [SEL_W-1:0]       sel_q;
    logic                   cpol_q;
    logic                   cpha_q;
    logic [div_width-1:0]   div_q;
    logic [DATA_WIDTH-1:0]  rx_q;

    // Starts while busy are dropped
    assign accept = (state == st_idle) && start_transfer;

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (accept)
                    next_state = st_setup;
            end
            st_setup: begin
                next_state = st_transfer;
            end
            st_transfer: begin
                if (cmd.last_edge)
                    next_state = st_complete;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= st_idle;
            cpol_q <= 1'b0;
            rx_q   <= '0;
        end else begin
            state <= next_state;
            if (accept)
                cpol_q <= cpol;
            if (state == st_complete)
                rx_q <= cmd.rx_word;
        end
    end

    // Command held stable from setup until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            tx_q   <= tx_data;
            sel_q  <= slave_sel;
            cpha_q <= cpha;
            div_q  <= clk_div;
        end
    end

    assign cmd.load    = (state == st_setup);
    assign cmd.run     = (state == st_transfer);
    assign cmd.tx_word = tx_q;
    assign cmd.cpol    = cpol_q;
    assign cmd.cpha    = cpha_q;
    assign cmd.clk_div = div_q;
    assign cmd.state   = state;

    assign busy          = (state == st_setup) || (state == st_transfer);
    assign transfer_done = (state == st_complete);

    // New word is visible during the done cycle itself
    assign rx_data = transfer_done ? cmd.rx_word : rx_q;

    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            spi_cs_n[i] = !((state != st_idle) && (sel_q == SEL_W'(i)));
        end
    end

    a_cs_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(~spi_cs_n)
    );

    // Done only follows the final serial clock edge
    a_done_after_last_edge: assert property (
        @(posedge clk) disable iff (!rst_n)
        transfer_done |-> ($past(state) == st_transfer) && $past(cmd.last_edge)
    );

endmodule

`default_nettype wire

// ==== verilog/spi_edge_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface spi_edge_if;

    // Serial clock level as seen on the pin
    logic sclk;

    // Single-cycle markers of the next sclk change
    logic lead_edge;
    logic trail_edge;

    modport gen_mp (
        output sclk, lead_edge, trail_edge
    );

    modport shift_mp (
        input sclk, lead_edge, trail_edge
    );

endinterface

`default_nettype wire

// ==== verilog/spi_cmd_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface spi_cmd_if #(
    parameter int DATA_WIDTH = 8
);
    import spi_pkg::*;

    // Sequencer controls and latched command
    logic                   load;
    logic                   run;
    logic [DATA_WIDTH-1:0]  tx_word;
    logic                   cpol;
    logic                   cpha;
    logic [div_width-1:0]   clk_div;
    logic [state_width-1:0] state;

    // Completion from the datapath stages
    logic                   last_edge;
    logic [DATA_WIDTH-1:0]  rx_word;

    modport seq_mp (
        output load, run, tx_word, cpol, cpha, clk_div, state,
        input  last_edge, rx_word
    );

    modport sclk_mp (
        input  run, cpol, clk_div,
        output last_edge
    );

    modport shift_mp (
        input  load, tx_word, cpha,
        output rx_word
    );

endinterface

`default_nettype wire

// ==== verilog/spi_pkg.sv ====
`default_nettype none

package spi_pkg;

    // Controller state encoding
    localparam int state_width = 2;

    localparam logic [state_width-1:0] st_idle     = 2'b00;
    localparam logic [state_width-1:0] st_setup    = 2'b01;
    localparam logic [state_width-1:0] st_transfer = 2'b10;
    localparam logic [state_width-1:0] st_complete = 2'b11;

    // Serial clock divider field
    localparam int div_width = 16;

endpackage

`default_nettype wire
